// ==== hw/sensor_link_pkg.sv ====
// Widths, reset settings and enums shared by the link; gaps below the sequencer minimum are stretched
package sensor_link_pkg;

	// Serial byte and setting widths
	localparam int BYTE_W = 8;
	localparam int CPB_W  = 12;
	localparam int GAP_W  = 16;

	// Settings after reset, in clock cycles
	localparam logic [CPB_W-1:0] CPB_RESET      = 12'd16;
	localparam logic [GAP_W-1:0] BYTE_GAP_RESET = 16'd4;
	localparam logic [GAP_W-1:0] PKT_GAP_RESET  = 16'd32;

	// Configuration register map
	typedef enum logic [1:0] {
		CFG_CPB      = 2'd0,
		CFG_BYTE_GAP = 2'd1,
		CFG_PKT_GAP  = 2'd2,
		CFG_ENABLE   = 2'd3
	} cfg_addr_e;

	// Byte sequencer states
	typedef enum logic [2:0] {
		SEQ_IDLE      = 3'd0,
		SEQ_LOAD      = 3'd1,
		SEQ_SEND      = 3'd2,
		SEQ_BYTE_REST = 3'd3,
		SEQ_PKT_REST  = 3'd4
	} seq_state_e;

	// UART transmitter states
	typedef enum logic [1:0] {
		TX_IDLE  = 2'd0,
		TX_START = 2'd1,
		TX_DATA  = 2'd2,
		TX_STOP  = 2'd3
	} tx_state_e;

endpackage

// ==== hw/link_config_regs.sv ====
// Host must hold address and data stable from req rise until ack; enable uses the low N_STREAMS bits
`timescale 1ns/1ps

module link_config_regs #(
	parameter int N_STREAMS = 4
) (
	input  logic                                 clock,
	input  logic                                 reset,
	input  logic                                 cfg_req_i,
	input  sensor_link_pkg::cfg_addr_e           cfg_addr_i,
	input  logic [15:0]                          cfg_wdata_i,
	output logic                                 cfg_ack_o,
	output logic [sensor_link_pkg::CPB_W-1:0]    cpb_o,
	output logic [sensor_link_pkg::GAP_W-1:0]    byte_gap_o,
	output logic [sensor_link_pkg::GAP_W-1:0]    pkt_gap_o,
	output logic [N_STREAMS-1:0]                 enable_o
);

	// Write once per request, then hold ack until req drops
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			cfg_ack_o  <= 1'b0;
			cpb_o      <= sensor_link_pkg::CPB_RESET;
			byte_gap_o <= sensor_link_pkg::BYTE_GAP_RESET;
			pkt_gap_o  <= sensor_link_pkg::PKT_GAP_RESET;
			enable_o   <= '0;
		end
		else if (cfg_req_i && !cfg_ack_o)
		begin
			cfg_ack_o <= 1'b1;
			case (cfg_addr_i)
				sensor_link_pkg::CFG_CPB:      cpb_o <= cfg_wdata_i[sensor_link_pkg::CPB_W-1:0];
				sensor_link_pkg::CFG_BYTE_GAP: byte_gap_o <= cfg_wdata_i;
				sensor_link_pkg::CFG_PKT_GAP:  pkt_gap_o <= cfg_wdata_i;
				default:                       enable_o <= cfg_wdata_i[N_STREAMS-1:0];
			endcase
		end
		else if (!cfg_req_i)
		begin
			cfg_ack_o <= 1'b0;
		end
	end

	// Ack only answers a request seen on the previous edge
	a_ack_after_req: assert property (@(posedge clock) disable iff (reset)
		$rose(cfg_ack_o) |-> $past(cfg_req_i));

endmodule

// ==== hw/stream_ingress.sv ====
// Source holds data until ack; ack is withheld while all FIFO_DEPTH packet slots are occupied
`timescale 1ns/1ps

module stream_ingress #(
	parameter int PAYLOAD_BYTES = 6,
	parameter int FIFO_DEPTH    = 2
) (
	input  logic                                              clock,
	input  logic                                              reset,
	input  logic                                              sens_req_i,
	input  logic [PAYLOAD_BYTES*sensor_link_pkg::BYTE_W-1:0]  sens_data_i,
	output logic                                              sens_ack_o,
	input  logic                                              pop_i,
	output logic                                              fifo_valid_o,
	output logic [PAYLOAD_BYTES*sensor_link_pkg::BYTE_W-1:0]  fifo_data_o
);

	localparam int PKT_W = PAYLOAD_BYTES * sensor_link_pkg::BYTE_W;
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FIFO_DEPTH - 1);
	localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(FIFO_DEPTH);

	logic [PKT_W-1:0] mem_q [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic             full;
	logic             push;

	assign full         = (count_q == FULL_CNT);
	assign push         = sens_req_i && !sens_ack_o && !full;
	assign fifo_valid_o = (count_q != '0);
	assign fifo_data_o  = mem_q[rd_ptr_q];

	// Handshake and circular pointers
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			sens_ack_o <= 1'b0;
			wr_ptr_q   <= '0;
			rd_ptr_q   <= '0;
			count_q    <= '0;
		end
		else
		begin
			if (push)
				sens_ack_o <= 1'b1;
			else if (!sens_req_i)
				sens_ack_o <= 1'b0;

			if (push)
				wr_ptr_q <= (wr_ptr_q == LAST_SLOT) ? '0 : wr_ptr_q + 1'b1;
			if (pop_i)
				rd_ptr_q <= (rd_ptr_q == LAST_SLOT) ? '0 : rd_ptr_q + 1'b1;

			case ({push, pop_i})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (push)
			mem_q[wr_ptr_q] <= sens_data_i;
	end

	// A write never lands on a slot that still holds an unread packet
	a_no_write_full: assert property (@(posedge clock) disable iff (reset)
		push |-> ((count_q == '0) || (wr_ptr_q != rd_ptr_q)));

	// Scheduler pops only a stream that holds a packet
	a_no_pop_empty: assert property (@(posedge clock) disable iff (reset)
		pop_i |-> fifo_valid_o);

endmodule

// ==== hw/packet_scheduler.sv ====
// Round-robin over enabled, non-empty streams; the frame buffer holds one packet until the next load
`timescale 1ns/1ps

module packet_scheduler #(
	parameter int N_STREAMS     = 4,
	parameter int PAYLOAD_BYTES = 6
) (
	input  logic                                                             clock,
	input  logic                                                             reset,
	input  logic [N_STREAMS-1:0]                                             enable_i,
	input  logic [N_STREAMS-1:0]                                             fifo_valid_i,
	input  logic [N_STREAMS-1:0][PAYLOAD_BYTES*sensor_link_pkg::BYTE_W-1:0]  fifo_data_i,
	input  logic                                                             load_i,
	input  logic [$clog2(PAYLOAD_BYTES+2)-1:0]                               byte_sel_i,
	output logic [N_STREAMS-1:0]                                             pop_o,
	output logic                                                             pkt_valid_o,
	output logic                                                             pending_o,
	output logic [sensor_link_pkg::BYTE_W-1:0]                               byte_o
);

	localparam int BYTE_W  = sensor_link_pkg::BYTE_W;
	localparam int PKT_W   = PAYLOAD_BYTES * BYTE_W;
	localparam int PKT_LEN = PAYLOAD_BYTES + 2;
	localparam int IDX_W   = $clog2(N_STREAMS);

	logic [N_STREAMS-1:0] ready;
	logic [IDX_W-1:0]     last_q;
	logic [IDX_W-1:0]     pick;
	logic                 found;
	logic [BYTE_W-1:0]    tag;
	logic [BYTE_W-1:0]    frame_q [PKT_LEN];

	assign ready     = enable_i & fifo_valid_i;
	assign pending_o = |ready;
	assign tag       = BYTE_W'(pick);
	assign byte_o    = (byte_sel_i < PKT_LEN) ? frame_q[byte_sel_i] : '0;

	// First ready stream after the last one served
	always_comb
	begin
		int cand;
		pick  = last_q;
		found = 1'b0;
		for (int k = 1; k <= N_STREAMS; k++)
		begin
			cand = (int'(last_q) + k) % N_STREAMS;
			if (!found && ready[cand])
			begin
				pick  = IDX_W'(cand);
				found = 1'b1;
			end
		end
		pop_o = '0;
		if (load_i && found)
			pop_o[pick] = 1'b1;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			last_q      <= IDX_W'(N_STREAMS - 1);
			pkt_valid_o <= 1'b0;
		end
		else if (load_i)
		begin
			pkt_valid_o <= found;
			if (found)
				last_q <= pick;
		end
	end

	// Tag, payload MSB first, tag
	always_ff @(posedge clock)
	begin
		if (load_i && found)
		begin
			frame_q[0] <= tag;
			for (int i = 0; i < PAYLOAD_BYTES; i++)
				frame_q[i+1] <= fifo_data_i[pick][PKT_W-1-i*BYTE_W -: BYTE_W];
			frame_q[PKT_LEN-1] <= tag;
		end
	end

	// One pop per load, on a ready stream, and the frame is marked valid next cycle
	a_pop_ready: assert property (@(posedge clock) disable iff (reset)
		(pop_o != '0) |-> ($onehot(pop_o) && ((pop_o & ~ready) == '0)) ##1 pkt_valid_o);

endmodule

// ==== hw/byte_sequencer.sv ====
// Idle-high gaps on the line equal the settings; byte gaps under 3 and packet gaps under 6 are stretched
`timescale 1ns/1ps

module byte_sequencer #(
	parameter int PAYLOAD_BYTES = 6
) (
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic                                  pending_i,
	input  logic                                  pkt_valid_i,
	input  logic [sensor_link_pkg::BYTE_W-1:0]    byte_i,
	input  logic [sensor_link_pkg::GAP_W-1:0]     byte_gap_i,
	input  logic [sensor_link_pkg::GAP_W-1:0]     pkt_gap_i,
	input  logic                                  tx_busy_i,
	output logic                                  load_o,
	output logic [$clog2(PAYLOAD_BYTES+2)-1:0]    byte_sel_o,
	output logic                                  tx_start_o,
	output logic [sensor_link_pkg::BYTE_W-1:0]    tx_data_o
);

	localparam int SEL_W   = $clog2(PAYLOAD_BYTES + 2);
	localparam int GAP_W   = sensor_link_pkg::GAP_W;
	localparam logic [SEL_W-1:0] LAST_SEL = SEL_W'(PAYLOAD_BYTES + 1);

	// Idle cycles on tx_o already spent in handover outside the rest states
	localparam logic [GAP_W-1:0] BYTE_GAP_ADJ = GAP_W'(3);
	localparam logic [GAP_W-1:0] PKT_GAP_ADJ  = GAP_W'(6);

	sensor_link_pkg::seq_state_e state_q;
	logic [GAP_W-1:0]            gap_cnt_q;
	logic                        issue;
	logic                        byte_done;

	// Start a byte after a fresh load or at the end of a byte rest
	assign issue = ((state_q == sensor_link_pkg::SEQ_LOAD) && !load_o && pkt_valid_i) ||
		((state_q == sensor_link_pkg::SEQ_BYTE_REST) && (gap_cnt_q <= BYTE_GAP_ADJ));

	// Busy rises the cycle after start, so a low busy without start means done
	assign byte_done = (state_q == sensor_link_pkg::SEQ_SEND) && !tx_start_o && !tx_busy_i;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state_q    <= sensor_link_pkg::SEQ_IDLE;
			gap_cnt_q  <= '0;
			load_o     <= 1'b0;
			byte_sel_o <= '0;
			tx_start_o <= 1'b0;
		end
		else
		begin
			tx_start_o <= issue;
			case (state_q)
				sensor_link_pkg::SEQ_IDLE:
				begin
					if (pending_i)
					begin
						load_o     <= 1'b1;
						byte_sel_o <= '0;
						state_q    <= sensor_link_pkg::SEQ_LOAD;
					end
				end
				sensor_link_pkg::SEQ_LOAD:
				begin
					load_o <= 1'b0;
					// Nothing was found if the mask changed after the request
					if (issue)
						state_q <= sensor_link_pkg::SEQ_SEND;
					else if (!load_o)
						state_q <= sensor_link_pkg::SEQ_IDLE;
				end
				sensor_link_pkg::SEQ_SEND:
				begin
					if (byte_done && (byte_sel_o == LAST_SEL))
					begin
						gap_cnt_q <= pkt_gap_i;
						state_q   <= sensor_link_pkg::SEQ_PKT_REST;
					end
					else if (byte_done)
					begin
						byte_sel_o <= byte_sel_o + 1'b1;
						gap_cnt_q  <= byte_gap_i;
						state_q    <= sensor_link_pkg::SEQ_BYTE_REST;
					end
				end
				sensor_link_pkg::SEQ_BYTE_REST:
				begin
					if (issue)
						state_q <= sensor_link_pkg::SEQ_SEND;
					else
						gap_cnt_q <= gap_cnt_q - 1'b1;
				end
				sensor_link_pkg::SEQ_PKT_REST:
				begin
					if (gap_cnt_q <= PKT_GAP_ADJ)
						state_q <= sensor_link_pkg::SEQ_IDLE;
					else
						gap_cnt_q <= gap_cnt_q - 1'b1;
				end
				default:
				begin
					state_q <= sensor_link_pkg::SEQ_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (issue)
			tx_data_o <= byte_i;
	end

	// Never start the transmitter mid-byte
	a_start_idle: assert property (@(posedge clock) disable iff (reset)
		tx_start_o |-> !tx_busy_i);

endmodule

// ==== hw/uart_tx.sv ====
// 8N1 transmitter; cpb must be at least 1 and is sampled at each byte start
`timescale 1ns/1ps

module uart_tx (
	input  logic                                clock,
	input  logic                                reset,
	input  logic [sensor_link_pkg::CPB_W-1:0]   cpb_i,
	input  logic                                tx_start_i,
	input  logic [sensor_link_pkg::BYTE_W-1:0]  tx_data_i,
	output logic                                tx_busy_o,
	output logic                                tx_o
);

	sensor_link_pkg::tx_state_e          state_q;
	logic [sensor_link_pkg::CPB_W-1:0]   cpb_q;
	logic [sensor_link_pkg::CPB_W-1:0]   cyc_cnt_q;
	logic [2:0]                          bit_idx_q;
	logic [sensor_link_pkg::BYTE_W-1:0]  shift_q;
	logic                                bit_end;

	assign tx_busy_o = (state_q != sensor_link_pkg::TX_IDLE);
	assign bit_end   = (cyc_cnt_q == cpb_q - 1'b1);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state_q   <= sensor_link_pkg::TX_IDLE;
			cyc_cnt_q <= '0;
			bit_idx_q <= '0;
			tx_o      <= 1'b1;
		end
		else
		begin
			cyc_cnt_q <= (bit_end || !tx_busy_o) ? '0 : cyc_cnt_q + 1'b1;
			case (state_q)
				sensor_link_pkg::TX_IDLE:
				begin
					if (tx_start_i)
					begin
						tx_o    <= 1'b0;
						state_q <= sensor_link_pkg::TX_START;
					end
				end
				sensor_link_pkg::TX_START:
				begin
					if (bit_end)
					begin
						tx_o      <= shift_q[0];
						bit_idx_q <= '0;
						state_q   <= sensor_link_pkg::TX_DATA;
					end
				end
				sensor_link_pkg::TX_DATA:
				begin
					if (bit_end && (bit_idx_q == 3'd7))
					begin
						tx_o    <= 1'b1;
						state_q <= sensor_link_pkg::TX_STOP;
					end
					else if (bit_end)
					begin
						tx_o      <= shift_q[1];
						bit_idx_q <= bit_idx_q + 1'b1;
					end
				end
				default:
				begin
					if (bit_end)
						state_q <= sensor_link_pkg::TX_IDLE;
				end
			endcase
		end
	end

	// LSB first, one shift per data bit
	always_ff @(posedge clock)
	begin
		if ((state_q == sensor_link_pkg::TX_IDLE) && tx_start_i)
		begin
			shift_q <= tx_data_i;
			cpb_q   <= cpb_i;
		end
		else if ((state_q == sensor_link_pkg::TX_DATA) && bit_end)
		begin
			shift_q <= shift_q >> 1;
		end
	end

endmodule

// ==== hw/sensor_bt_link.sv ====
// Nothing is sent until the enable mask is written; N_STREAMS must be 2 to 8
`timescale 1ns/1ps

module sensor_bt_link #(
	parameter int N_STREAMS     = 4,
	parameter int PAYLOAD_BYTES = 6,
	parameter int FIFO_DEPTH    = 2
) (
	input  logic                                                             clock,
	input  logic                                                             reset,
	input  logic                                                             cfg_req_i,
	input  sensor_link_pkg::cfg_addr_e                                       cfg_addr_i,
	input  logic [15:0]                                                      cfg_wdata_i,
	output logic                                                             cfg_ack_o,
	input  logic [N_STREAMS-1:0]                                             sens_req_i,
	input  logic [N_STREAMS-1:0][PAYLOAD_BYTES*sensor_link_pkg::BYTE_W-1:0]  sens_data_i,
	output logic [N_STREAMS-1:0]                                             sens_ack_o,
	output logic                                                             tx_o
);

	localparam int PKT_W = PAYLOAD_BYTES * sensor_link_pkg::BYTE_W;
	localparam int SEL_W = $clog2(PAYLOAD_BYTES + 2);

	// Settings
	logic [sensor_link_pkg::CPB_W-1:0]  cpb;
	logic [sensor_link_pkg::GAP_W-1:0]  byte_gap;
	logic [sensor_link_pkg::GAP_W-1:0]  pkt_gap;
	logic [N_STREAMS-1:0]               enable;

	// Stream FIFOs to scheduler
	logic [N_STREAMS-1:0]               fifo_valid;
	logic [N_STREAMS-1:0][PKT_W-1:0]    fifo_data;
	logic [N_STREAMS-1:0]               pop;

	// Scheduler, sequencer and transmitter
	logic                               pkt_valid;
	logic                               pending;
	logic [sensor_link_pkg::BYTE_W-1:0] pkt_byte;
	logic                               load;
	logic [SEL_W-1:0]                   byte_sel;
	logic                               tx_start;
	logic [sensor_link_pkg::BYTE_W-1:0] tx_data;
	logic                               tx_busy;

	link_config_regs #(
		.N_STREAMS(N_STREAMS)
	) u_link_config_regs (
		.clock(clock),
		.reset(reset),
		.cfg_req_i(cfg_req_i),
		.cfg_addr_i(cfg_addr_i),
		.cfg_wdata_i(cfg_wdata_i),
		.cfg_ack_o(cfg_ack_o),
		.cpb_o(cpb),
		.byte_gap_o(byte_gap),
		.pkt_gap_o(pkt_gap),
		.enable_o(enable)
	);

	for (genvar s = 0; s < N_STREAMS; s++)
	begin : g_stream
		stream_ingress #(
			.PAYLOAD_BYTES(PAYLOAD_BYTES),
			.FIFO_DEPTH(FIFO_DEPTH)
		) u_stream_ingress (
			.clock(clock),
			.reset(reset),
			.sens_req_i(sens_req_i[s]),
			.sens_data_i(sens_data_i[s]),
			.sens_ack_o(sens_ack_o[s]),
			.pop_i(pop[s]),
			.fifo_valid_o(fifo_valid[s]),
			.fifo_data_o(fifo_data[s])
		);
	end

	packet_scheduler #(
		.N_STREAMS(N_STREAMS),
		.PAYLOAD_BYTES(PAYLOAD_BYTES)
	) u_packet_scheduler (
		.clock(clock),
		.reset(reset),
		.enable_i(enable),
		.fifo_valid_i(fifo_valid),
		.fifo_data_i(fifo_data),
		.load_i(load),
		.byte_sel_i(byte_sel),
		.pop_o(pop),
		.pkt_valid_o(pkt_valid),
		.pending_o(pending),
		.byte_o(pkt_byte)
	);

	byte_sequencer #(
		.PAYLOAD_BYTES(PAYLOAD_BYTES)
	) u_byte_sequencer (
		.clock(clock),
		.reset(reset),
		.pending_i(pending),
		.pkt_valid_i(pkt_valid),
		.byte_i(pkt_byte),
		.byte_gap_i(byte_gap),
		.pkt_gap_i(pkt_gap),
		.tx_busy_i(tx_busy),
		.load_o(load),
		.byte_sel_o(byte_sel),
		.tx_start_o(tx_start),
		.tx_data_o(tx_data)
	);

	uart_tx u_uart_tx (
		.clock(clock),
		.reset(reset),
		.cpb_i(cpb),
		.tx_start_i(tx_start),
		.tx_data_i(tx_data),
		.tx_busy_o(tx_busy),
		.tx_o(tx_o)
	);

endmodule

// ==== test/tb_sensor_bt_link.sv ====
// Run from the project root; expects 4 streams, 6-byte payloads and 2-deep FIFOs in the DUT
`timescale 1ns/1ps

module tb_sensor_bt_link;

	localparam int N_STREAMS     = 4;
	localparam int PAYLOAD_BYTES = 6;
	localparam int FIFO_DEPTH    = 2;
	localparam int PKT_W         = PAYLOAD_BYTES * 8;
	localparam int PKT_LEN       = PAYLOAD_BYTES + 2;
	localparam int REC_W         = PKT_W + 8;
	localparam int STIM_MAX      = 64;
	localparam int HALF_PERIOD   = 5;
	localparam int DRIVE_DLY     = 1;
	localparam int SETTLE        = 100;
	localparam int BLOCK_HOLD    = 40;
	localparam int MARGIN        = 2000;
	localparam logic [31:0] SEED = 32'ha7f3_a6c7;

	logic                             clock;
	logic                             reset;
	logic                             cfg_req;
	sensor_link_pkg::cfg_addr_e       cfg_addr;
	logic [15:0]                      cfg_wdata;
	logic                             cfg_ack;
	logic [N_STREAMS-1:0]             sens_req;
	logic [N_STREAMS-1:0][PKT_W-1:0]  sens_data;
	logic [N_STREAMS-1:0]             sens_ack;
	logic                             tx;

	logic [REC_W-1:0] stim [STIM_MAX];
	integer           seed;
	int               cycle_cnt;
	int               cycle_limit;
	int               checks;
	int               errors;
	int               test_errors;
	string            test_name;

	// Reference model of the link as the host programmed it
	logic [11:0]          cpb_cfg;
	logic [15:0]          byte_gap_cfg;
	logic [15:0]          pkt_gap_cfg;
	logic [N_STREAMS-1:0] enable_cfg;
	int                   last_served;
	logic [PKT_W-1:0]     model_mem [N_STREAMS][8];
	int                   model_head [N_STREAMS];
	int                   model_cnt [N_STREAMS];
	logic [7:0]           exp_frame [PKT_LEN];
	int                   byte_idx;
	int                   frames_done;
	int                   bytes_done;
	int                   frames_at_start;
	int                   bytes_at_start;
	logic                 gap_check;

	sensor_bt_link #(
		.N_STREAMS(N_STREAMS),
		.PAYLOAD_BYTES(PAYLOAD_BYTES),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_sensor_bt_link (
		.clock(clock),
		.reset(reset),
		.cfg_req_i(cfg_req),
		.cfg_addr_i(cfg_addr),
		.cfg_wdata_i(cfg_wdata),
		.cfg_ack_o(cfg_ack),
		.sens_req_i(sens_req),
		.sens_data_i(sens_data),
		.sens_ack_o(sens_ack),
		.tx_o(tx)
	);

	initial clock = 1'b0;

	always #HALF_PERIOD clock = ~clock;

	always @(posedge clock)
	begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit)
		begin
			$display("Timeout after %0d cycles, the link stopped answering or sending", cycle_cnt);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic string name_of_test(input logic [3:0] n);
		case (n)
			4'd1:    return "silent_while_disabled";
			4'd2:    return "frame_format";
			4'd3:    return "round_robin";
			4'd4:    return "back_pressure";
			4'd5:    return "spacing_and_bit_period";
			default: return "unnamed";
		endcase
	endfunction

	task automatic compare_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			test_errors++;
			$display("** Error %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
		end
	endtask

	task automatic config_write(input logic [1:0] addr, input logic [15:0] data);
		@(posedge clock);
		#DRIVE_DLY;
		cfg_addr  = sensor_link_pkg::cfg_addr_e'(addr);
		cfg_wdata = data;
		cfg_req   = 1'b1;
		while (cfg_ack !== 1'b1)
		begin
			@(posedge clock);
			#DRIVE_DLY;
		end
		// Register takes the value on the edge that raises ack
		case (addr)
			2'd0:    cpb_cfg = data[11:0];
			2'd1:    byte_gap_cfg = data;
			2'd2:    pkt_gap_cfg = data;
			default: enable_cfg = data[N_STREAMS-1:0];
		endcase
		cfg_req = 1'b0;
		while (cfg_ack !== 1'b0)
		begin
			@(posedge clock);
			#DRIVE_DLY;
		end
	endtask

	task automatic raise_request(input int s, input logic [PKT_W-1:0] data);
		@(posedge clock);
		#DRIVE_DLY;
		sens_data[s] = data;
		sens_req[s]  = 1'b1;
	endtask

	// Rest of the four-phase cycle; an acked packet is in the stream FIFO
	task automatic complete_request(input int s);
		while (sens_ack[s] !== 1'b1)
		begin
			@(posedge clock);
			#DRIVE_DLY;
		end
		model_mem[s][(model_head[s] + model_cnt[s]) % 8] = sens_data[s];
		model_cnt[s]++;
		sens_req[s] = 1'b0;
		while (sens_ack[s] !== 1'b0)
		begin
			@(posedge clock);
			#DRIVE_DLY;
		end
	endtask

	task automatic check_byte(input logic [7:0] rx, input int idle, input logic stop);
		int               pick;
		int               pos;
		int               k;
		int               i;
		logic [PKT_W-1:0] payload;
		if (byte_idx == 0)
		begin
			// Next enabled stream with a packet, after the one served last
			pick = -1;
			for (k = 1; k <= N_STREAMS; k++)
			begin
				pos = (last_served + k) % N_STREAMS;
				if (pick < 0 && enable_cfg[pos] && model_cnt[pos] > 0)
					pick = pos;
			end
			if (pick < 0)
			begin
				$display("Test %s: a frame started while no enabled stream held a packet",
					test_name);
				errors++;
				test_errors++;
				for (i = 0; i < PKT_LEN; i++)
					exp_frame[i] = 8'h00;
			end
			else
			begin
				payload = model_mem[pick][model_head[pick]];
				model_head[pick] = (model_head[pick] + 1) % 8;
				model_cnt[pick]--;
				last_served = pick;
				exp_frame[0] = 8'(pick);
				for (i = 0; i < PAYLOAD_BYTES; i++)
					exp_frame[i+1] = payload[PKT_W-1-8*i -: 8];
				exp_frame[PKT_LEN-1] = 8'(pick);
			end
			if (gap_check && frames_done > frames_at_start)
				compare_value("packet gap", pkt_gap_cfg, idle);
		end
		else
		begin
			compare_value("byte gap", byte_gap_cfg, idle);
		end
		compare_value($sformatf("frame byte %0d", byte_idx), exp_frame[byte_idx], rx);
		compare_value("stop bit", 1, stop);
		bytes_done++;
		if (byte_idx == PKT_LEN - 1)
		begin
			byte_idx = 0;
			frames_done++;
		end
		else
		begin
			byte_idx++;
		end
	endtask

	// UART decoder, samples mid-bit on the falling clock edge
	initial
	begin : uart_decoder
		int         idle;
		int         bit_len;
		int         b;
		logic [7:0] rx;
		logic       stop;
		idle = 0;
		@(negedge clock);
		while (reset !== 1'b0)
			@(negedge clock);
		forever
		begin
			if (tx !== 1'b0)
			begin
				idle++;
				@(negedge clock);
			end
			else
			begin
				bit_len = cpb_cfg;
				repeat (bit_len + bit_len / 2) @(negedge clock);
				for (b = 0; b < 8; b++)
				begin
					rx[b] = tx;
					repeat (bit_len) @(negedge clock);
				end
				stop = tx;
				check_byte(rx, idle, stop);
				// Idle count starts at the first cycle after the stop bit
				repeat (bit_len - bit_len / 2) @(negedge clock);
				idle = 0;
			end
		end
	end

	initial
	begin : run_stim
		logic [3:0]       op;
		logic [3:0]       arg;
		logic [PKT_W-1:0] data;
		int               i;
		int               n_recs;
		int               n_pkts;
		int               n_tests;
		int               max_cpb;
		int               max_byte_gap;
		int               max_pkt_gap;
		int               frames_exp;
		int               delay;
		int               low_cycles;
		reset       = 1'b1;
		cfg_req     = 1'b0;
		cfg_addr    = sensor_link_pkg::CFG_CPB;
		cfg_wdata   = '0;
		sens_req    = '0;
		sens_data   = '0;
		seed        = SEED;
		cycle_cnt   = 0;
		cycle_limit = 32'h7fff_ffff;
		checks      = 0;
		errors      = 0;
		test_errors = 0;
		test_name   = "setup";
		cpb_cfg      = 12'd16;
		byte_gap_cfg = 16'd4;
		pkt_gap_cfg  = 16'd32;
		enable_cfg   = '0;
		last_served  = N_STREAMS - 1;
		for (i = 0; i < N_STREAMS; i++)
		begin
			model_head[i] = 0;
			model_cnt[i]  = 0;
		end
		byte_idx        = 0;
		frames_done     = 0;
		bytes_done      = 0;
		frames_at_start = 0;
		bytes_at_start  = 0;
		gap_check       = 1'b0;
		n_tests         = 0;
		$readmemh("test/link_stim.txt", stim);

		n_recs = 0;
		while (n_recs < STIM_MAX && !$isunknown(stim[n_recs]) &&
			stim[n_recs][REC_W-1 -: 4] != 4'h0)
			n_recs++;

		// Limit from the slowest settings and every packet in the file
		n_pkts       = 0;
		max_cpb      = cpb_cfg;
		max_byte_gap = byte_gap_cfg;
		max_pkt_gap  = pkt_gap_cfg;
		for (i = 0; i < n_recs; i++)
		begin
			op   = stim[i][REC_W-1 -: 4];
			arg  = stim[i][REC_W-5 -: 4];
			data = stim[i][PKT_W-1:0];
			if (op == 4'h1 && arg == 4'h0 && int'(data[15:0]) > max_cpb)
				max_cpb = int'(data[15:0]);
			if (op == 4'h1 && arg == 4'h1 && int'(data[15:0]) > max_byte_gap)
				max_byte_gap = int'(data[15:0]);
			if (op == 4'h1 && arg == 4'h2 && int'(data[15:0]) > max_pkt_gap)
				max_pkt_gap = int'(data[15:0]);
			if (op == 4'h2 || op == 4'h5)
				n_pkts++;
		end
		cycle_limit = n_pkts * (PKT_LEN * (10 * max_cpb + max_byte_gap) + max_pkt_gap) +
			n_recs * (SETTLE + BLOCK_HOLD) + MARGIN;

		repeat (8) @(posedge clock);
		#DRIVE_DLY;
		reset = 1'b0;

		for (i = 0; i < n_recs; i++)
		begin
			op   = stim[i][REC_W-1 -: 4];
			arg  = stim[i][REC_W-5 -: 4];
			data = stim[i][PKT_W-1:0];
			case (op)
				4'h1: config_write(arg[1:0], data[15:0]);
				4'h2:
				begin
					delay = $unsigned($random(seed)) % 4;
					repeat (delay) @(posedge clock);
					raise_request(arg, data);
					complete_request(arg);
				end
				4'h3:
				begin
					test_name       = name_of_test(arg);
					test_errors     = 0;
					gap_check       = data[0];
					frames_at_start = frames_done;
					bytes_at_start  = bytes_done;
				end
				4'h4:
				begin
					frames_exp = int'(data[15:0]);
					while (frames_done < frames_at_start + frames_exp)
						@(posedge clock);
					// Line must stay quiet once the expected frames are out
					low_cycles = 0;
					repeat (SETTLE)
					begin
						@(posedge clock);
						#DRIVE_DLY;
						if (tx !== 1'b1)
							low_cycles++;
					end
					compare_value("low cycles after last frame", 0, low_cycles);
					compare_value("byte count", frames_exp * PKT_LEN, bytes_done - bytes_at_start);
					n_tests++;
					if (test_errors == 0)
						$display("Test %0d %s: %0d frames, ok", arg, test_name, frames_exp);
					else
						$display("Test %0d %s: %0d frames, %0d errors", arg, test_name,
							frames_exp, test_errors);
				end
				4'h5:
				begin
					raise_request(arg, data);
					repeat (BLOCK_HOLD)
					begin
						@(posedge clock);
						#DRIVE_DLY;
						compare_value("ack while FIFO full", 0, sens_ack[arg]);
					end
				end
				4'h6: complete_request(arg);
				default:
				begin
					$display("Stim record %0d has an unknown opcode %0h", i, op);
					errors++;
				end
			endcase
		end

		$display("Summary: %0d tests, %0d checks, %0d errors", n_tests, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== test/link_stim.txt ====
// Record: op (1 hex) arg (1 hex) data (12 hex); op 1 config write, arg is the register address
// op 2 packet on stream arg, 3 test start (data bit 0 checks packet gaps), 4 test end (frames), 5 held request, 6 release
10000000000008
11000000000004
12000000000020
// Test 1, packets while the enable mask is 0
31000000000000
20a1a2a3a4a5a6
21b1b2b3b4b5b6
41000000000000
// Test 2, stream 2 alone
32000000000000
13000000000004
22c1c2c3c4c5c6
42000000000001
// Test 3, unequal counts then all streams enabled
33000000000001
13000000000000
20d1d2d3d4d5d6
22e1e2e3e4e5e6
22f10203040506
1300000000000f
43000000000005
// Test 4, stream 1 full then one more request
34000000000000
13000000000000
21112233445566
21778899aabbcc
51ddeeff001122
13000000000002
61000000000000
44000000000003
// Test 5, new bit period and gaps
35000000000001
10000000000005
11000000000007
12000000000014
13000000000008
235a5a0f0f3c3c
23c35a96e17f80
2300ff0180fe7e
45000000000003

// ==== all.f ====
hw/sensor_link_pkg.sv
hw/link_config_regs.sv
hw/stream_ingress.sv
hw/packet_scheduler.sv
hw/byte_sequencer.sv
hw/uart_tx.sv
hw/sensor_bt_link.sv
test/tb_sensor_bt_link.sv
